// File: bench/desc_queue_checks.svh
`ifndef DESC_QUEUE_CHECKS_SVH
`define DESC_QUEUE_CHECKS_SVH

// ------------------------------
// compare tasks
// ------------------------------

// descriptor read back from the queue against the model's copy
// the field split on a second line makes a swapped or torn word easy to spot
task automatic check_desc(input string name, input desc_t actual, input desc_t expected);
  if (actual !== expected) begin
    desc_errors++;
    $display("CHECK FAILED %s at %0t: got %h expected %h", name, $time, actual, expected);
    $display("  op %h/%h len %h/%h buf_addr %h/%h tag %h/%h",
             actual.op, expected.op, actual.len, expected.len,
             actual.buf_addr, expected.buf_addr, actual.tag, expected.tag);
  end
endtask

// whole status bundle, levels and pulses in one compare
task automatic check_status(input string name, input queue_status_t actual,
                            input queue_status_t expected);
  if (actual !== expected) begin
    status_errors++;
    $display("CHECK FAILED %s at %0t: got %h expected %h", name, $time, actual, expected);
    $display("  count %h/%h full %h/%h empty %h/%h overflow %h/%h underflow %h/%h",
             actual.count, expected.count, actual.full, expected.full,
             actual.empty, expected.empty, actual.overflow, expected.overflow,
             actual.underflow, expected.underflow);
  end
endtask

// the valid pulse must follow every accepted pop and nothing else
task automatic check_pop_valid(input string name, input logic actual, input logic expected);
  if (actual !== expected) begin
    valid_errors++;
    $display("CHECK FAILED %s at %0t: got %h expected %h", name, $time, actual, expected);
  end
endtask

// ------------------------------
// other failures
// ------------------------------

// a problem that is not a wrong value, such as a behavior that never occurred
task automatic flag_problem(input string what);
  other_errors++;
  $display("problem at %0t: %s", $time, what);
endtask

`endif

// File: bench/desc_queue_tb.sv
`default_nettype none

`include "desc_params.svh"

module desc_queue_tb
  import desc_pkg::*;
  import queue_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD   = 20;
  localparam int RESET_CYCLES = 8;
  localparam int DEPTH        = `DESC_QUEUE_DEPTH;

  // phase lengths in cycles
  // the fill and drain phases run well past depth
  localparam int MIX_CYCLES    = 300;
  localparam int FILL_CYCLES   = 2 * DEPTH + 8;
  localparam int SWAP_CYCLES   = 40;
  localparam int DRAIN_CYCLES  = 2 * DEPTH + 8;
  localparam int WDIS_CYCLES   = 250;
  localparam int TAIL_CYCLES   = 4;
  localparam int TOTAL_CYCLES  = 2 * MIX_CYCLES + FILL_CYCLES + SWAP_CYCLES + DRAIN_CYCLES
                               + WDIS_CYCLES + TAIL_CYCLES;
  localparam int MARGIN_CYCLES = 50;

  logic          clk;
  logic          reset;
  logic          push;
  desc_t         push_desc;
  logic          pop;
  logic          mem_wr_disable;
  desc_t         pop_desc;
  logic          pop_valid;
  queue_status_t status;

  integer seed;

  // reference model of the array, the pointers and the occupancy
  desc_t model_mem [DEPTH];
  logic  model_stale [DEPTH];
  int    model_wr;
  int    model_rd;
  int    model_count;

  // what the DUT should show during the current cycle
  logic          exp_valid;
  desc_t         exp_desc;
  queue_status_t exp_status;
  logic          checking;

  int desc_errors;
  int status_errors;
  int valid_errors;
  int other_errors;

  // tallies that show the interesting cases were actually reached
  int pops_seen;
  int full_seen;
  int overflows_seen;
  int underflows_seen;
  int stale_pops_seen;

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  desc_queue DUT (
    .clk            (clk),
    .reset          (reset),
    .push           (push),
    .push_desc      (push_desc),
    .pop            (pop),
    .mem_wr_disable (mem_wr_disable),
    .pop_desc       (pop_desc),
    .pop_valid      (pop_valid),
    .status         (status)
  );

  `include "desc_queue_checks.svh"

  // ------------------------------
  // stimulus
  // ------------------------------

  // true with the given percentage, drawn from the seeded generator
  function automatic logic chance(input int pct);
    int r;
    r = $random(seed) % 100;
    if (r < 0) r = -r;
    return (r < pct);
  endfunction

  function automatic desc_t random_desc();
    desc_t    d;
    logic [1:0] sel;
    sel = 2'($random(seed));
    case (sel)
      2'd0:    d.op = DESC_OP_READ;
      2'd1:    d.op = DESC_OP_WRITE;
      2'd2:    d.op = DESC_OP_FLUSH;
      default: d.op = DESC_OP_NOP;
    endcase
    d.len      = 12'($random(seed));
    d.buf_addr = $random(seed);
    d.tag      = 8'($random(seed));
    return d;
  endfunction

  // one phase of random strobes
  // new values land just after each rising edge
  task automatic run_phase(input int cycles, input int push_pct, input int pop_pct,
                           input int wdis_pct);
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      push           <= chance(push_pct);
      pop            <= chance(pop_pct);
      mem_wr_disable <= chance(wdis_pct);
      push_desc      <= random_desc();
    end
  endtask

  // ------------------------------
  // reference model
  // ------------------------------

  // steps on the same edge as the DUT and sees the inputs of the cycle that ends
  always @(posedge clk) begin : model_step
    logic full_now;
    logic empty_now;
    logic push_ok;
    logic pop_ok;
    logic ovf;
    logic udf;
    full_now  = (model_count == DEPTH);
    empty_now = (model_count == 0);
    pop_ok    = pop && !empty_now;
    push_ok   = push && (!full_now || pop_ok);
    ovf       = 1'b0;
    udf       = 1'b0;
    if (reset) begin
      model_wr    = 0;
      model_rd    = 0;
      model_count = 0;
      exp_valid   = 1'b0;
    end else begin
      // the pop reads its slot before this cycle's push, which matters when full
      exp_valid = pop_ok;
      if (pop_ok) begin
        exp_desc = model_mem[model_rd];
        pops_seen++;
        if (model_stale[model_rd]) stale_pops_seen++;
      end
      // a blocked write leaves the old word in place and marks the slot
      if (push_ok) begin
        if (!mem_wr_disable) model_mem[model_wr] = push_desc;
        model_stale[model_wr] = mem_wr_disable;
        model_wr = (model_wr + 1) % DEPTH;
      end
      if (pop_ok) model_rd = (model_rd + 1) % DEPTH;
      if (push_ok && !pop_ok) model_count++;
      else if (pop_ok && !push_ok) model_count--;
      ovf = push && !push_ok;
      udf = pop && empty_now;
      if (ovf) overflows_seen++;
      if (udf) underflows_seen++;
      if (model_count == DEPTH) full_seen++;
    end
    exp_status.count     = queue_count_t'(model_count);
    exp_status.full      = (model_count == DEPTH);
    exp_status.empty     = (model_count == 0);
    exp_status.overflow  = ovf;
    exp_status.underflow = udf;
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (checking) begin
      check_status("status", status, exp_status);
      check_pop_valid("pop_valid", pop_valid, exp_valid);
      if (exp_valid) check_desc("pop_desc", pop_desc, exp_desc);
    end
  end

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin : main
    queue_status_t reset_status;
    int            total;
    seed            = 845;
    reset           = 1'b1;
    push            = 1'b0;
    pop             = 1'b0;
    mem_wr_disable  = 1'b0;
    push_desc       = '0;
    checking        = 1'b0;
    desc_errors     = 0;
    status_errors   = 0;
    valid_errors    = 0;
    other_errors    = 0;
    pops_seen       = 0;
    full_seen       = 0;
    overflows_seen  = 0;
    underflows_seen = 0;
    stale_pops_seen = 0;
    for (int i = 0; i < DEPTH; i++) model_stale[i] = 1'b0;

    repeat (RESET_CYCLES) @(posedge clk);
    reset    <= 1'b0;
    checking  = 1'b1;

    // an empty queue with no pulses is the only legal state after reset
    reset_status       = '0;
    reset_status.empty = 1'b1;
    @(negedge clk);
    check_pop_valid("pop_valid after reset", pop_valid, 1'b0);
    check_status("status after reset", status, reset_status);

    // the write disable stays off until every slot has held a pushed word
    run_phase(MIX_CYCLES, 50, 50, 0);
    run_phase(FILL_CYCLES, 100, 0, 0);
    run_phase(SWAP_CYCLES, 100, 60, 0);
    run_phase(DRAIN_CYCLES, 0, 100, 0);
    run_phase(WDIS_CYCLES, 55, 45, 40);
    run_phase(MIX_CYCLES, 50, 50, 10);

    // idle a few cycles so the last pop results are compared
    @(posedge clk);
    push           <= 1'b0;
    pop            <= 1'b0;
    mem_wr_disable <= 1'b0;
    repeat (TAIL_CYCLES) @(posedge clk);
    // the compare of the last falling edge has already run by now
    checking = 1'b0;
    @(negedge clk);

    if (pops_seen == 0) flag_problem("no pop was ever accepted");
    if (full_seen == 0) flag_problem("the queue never filled to depth");
    if (overflows_seen == 0) flag_problem("no push was ever refused while full");
    if (underflows_seen == 0) flag_problem("no pop was ever made while empty");
    if (stale_pops_seen == 0) flag_problem("no slot written under write disable was popped");

    total = desc_errors + status_errors + valid_errors + other_errors;
    $display("summary: desc errors %0d, status errors %0d, pop_valid errors %0d, other %0d",
             desc_errors, status_errors, valid_errors, other_errors);
    if (total == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  // bound on the whole run from the phase lengths
  initial begin : watchdog
    #((RESET_CYCLES + TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("watchdog expired before the test sequence finished");
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/desc_fifo_ctrl.sv
`default_nettype none

`include "desc_params.svh"

// pointer, occupancy and status control for the descriptor queue
// turns plain push and pop strobes into write and read strobes on the
// latch-array memory and registers the pop valid and error pulses
module desc_fifo_ctrl
  import queue_pkg::*;
(
  input  wire logic                    clk,
  input  wire logic                    reset,
  input  wire logic                    push,
  input  wire logic                    pop,
  output logic                         wen,
  output logic                         ren,
  output logic      [`DESC_ADDR_W-1:0] wadr,
  output logic      [`DESC_ADDR_W-1:0] radr,
  output logic                         pop_valid,
  output queue_status_t                status
);

  // last slot index, where the pointers wrap back to zero
  localparam logic [`DESC_ADDR_W-1:0] LAST_SLOT = `DESC_ADDR_W'(`DESC_QUEUE_DEPTH - 1);

  // ------------------------------
  // state
  // ------------------------------

  logic [`DESC_ADDR_W-1:0] wr_ptr;
  logic [`DESC_ADDR_W-1:0] rd_ptr;
  queue_count_t            count;

  // registered pulses
  logic pop_valid_q;
  logic overflow_q;
  logic underflow_q;

  // fill levels follow straight from the registered count
  logic full;
  logic empty;

  // strobes that were accepted this cycle
  logic push_ok;
  logic pop_ok;

  // next occupancy
  queue_count_t count_nxt;

  assign full  = (count == QUEUE_FULL_COUNT);
  assign empty = (count == '0);

  // ------------------------------
  // acceptance
  // ------------------------------

  // a pop needs something stored
  assign pop_ok = pop & ~empty;

  // a push needs a free slot, or the slot freed by a pop in the same cycle
  // when full both pointers are equal and the memory still hands the old
  // word to the pop because its write lands one edge later
  assign push_ok = push & (~full | pop_ok);

  // memory strobes go out in the same cycle as the accepted strobe
  assign wen  = push_ok;
  assign wadr = wr_ptr;
  assign ren  = pop_ok;
  assign radr = rd_ptr;

  // occupancy only moves when exactly one side was accepted
  always_comb begin
    count_nxt = count;
    case ({push_ok, pop_ok})
      2'b10:   count_nxt = count + 1'b1;
      2'b01:   count_nxt = count - 1'b1;
      default: count_nxt = count;
    endcase
  end

  // ------------------------------
  // pointer and count registers
  // ------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // wrap explicitly so a depth that is not a power of two still works
      if (push_ok) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_nxt;
    end
  end

  // ------------------------------
  // pulses
  // ------------------------------

  // the memory output is valid one cycle after the read strobe, so the
  // valid pulse is the accepted pop delayed by one register
  // overflow covers a push refused while full, underflow a pop while empty
  always_ff @(posedge clk) begin
    if (reset) begin
      pop_valid_q <= 1'b0;
      overflow_q  <= 1'b0;
      underflow_q <= 1'b0;
    end else begin
      pop_valid_q <= pop_ok;
      overflow_q  <= push & ~push_ok;
      underflow_q <= pop & empty;
    end
  end

  assign pop_valid = pop_valid_q;

  always_comb begin
    status           = '0;
    status.count     = count;
    status.full      = full;
    status.empty     = empty;
    status.overflow  = overflow_q;
    status.underflow = underflow_q;
  end

  // ------------------------------
  // checks
  // ------------------------------

  // equal pointers mean empty or full, so a read on equal pointers
  // is only legal when the count says the queue is full
  a_no_read_when_empty : assert property (@(posedge clk) disable iff (reset)
    ren |-> (rd_ptr != wr_ptr || count == QUEUE_FULL_COUNT))
    else $error("read strobe issued while the queue is empty");

  // a write on equal pointers needs an empty queue or a pop beside it
  a_no_write_when_full : assert property (@(posedge clk) disable iff (reset)
    wen |-> (wr_ptr != rd_ptr || count == '0 || ren))
    else $error("write strobe issued while full without a matching pop");

  // occupancy stays inside the array
  a_count_bound : assert property (@(posedge clk) disable iff (reset)
    count <= QUEUE_FULL_COUNT)
    else $error("count %0d exceeds depth", count);

endmodule

`default_nettype wire

// File: logic/desc_params.svh
`ifndef DESC_PARAMS_SVH
`define DESC_PARAMS_SVH

// number of descriptor slots in the queue
`define DESC_QUEUE_DEPTH 16

// pointer width, enough to index every slot
`define DESC_ADDR_W 4

// 1 makes the memory model drive X on the cycle after a cycle without a read
`define DESC_X_ON_IDLE 1

`endif

// File: logic/desc_pkg.sv
`default_nettype none

// ------------------------------
// descriptor payload types
// ------------------------------

package desc_pkg;

  // opcode carried in the top nibble of every descriptor
  typedef enum logic [3:0] {
    DESC_OP_READ  = 4'h0,
    DESC_OP_WRITE = 4'h1,
    DESC_OP_FLUSH = 4'h2,
    DESC_OP_NOP   = 4'hf
  } desc_op_t;

  // one queued descriptor, 56 bits with the opcode in the msbs
  typedef struct packed {
    desc_op_t    op;
    logic [11:0] len;
    // byte address of the buffer the descriptor points at
    logic [31:0] buf_addr;
    // free tag that the consumer uses to match completions
    logic [7:0]  tag;
  } desc_t;

  // width of a descriptor as a flat memory word
  localparam int DESC_W = $bits(desc_t);

endpackage

`default_nettype wire

// File: logic/desc_queue.sv
`default_nettype none

`include "desc_params.svh"

// descriptor queue top
// the control block owns pointers and status, the latch-array model holds
// the descriptors as flat words of the descriptor width
module desc_queue
  import desc_pkg::*;
  import queue_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  push,
  input  wire desc_t push_desc,
  input  wire logic  pop,
  input  wire logic  mem_wr_disable,
  output desc_t      pop_desc,
  output logic       pop_valid,
  output queue_status_t status
);

  // ------------------------------
  // control to memory wires
  // ------------------------------

  logic                    mem_wen;
  logic                    mem_ren;
  logic [`DESC_ADDR_W-1:0] mem_wadr;
  logic [`DESC_ADDR_W-1:0] mem_radr;

  // raw memory word, recast to a descriptor on the way out
  logic [DESC_W-1:0]       mem_dout;

  desc_fifo_ctrl u_ctrl (
    .clk       (clk),
    .reset     (reset),
    .push      (push),
    .pop       (pop),
    .wen       (mem_wen),
    .ren       (mem_ren),
    .wadr      (mem_wadr),
    .radr      (mem_radr),
    .pop_valid (pop_valid),
    .status    (status)
  );

  // descriptor goes in as its packed bits, opcode in the msbs
  lamb_1r1w_mem #(
    .DEPTH        (`DESC_QUEUE_DEPTH),
    .DWIDTH       (DESC_W),
    .X_ON_NOT_REN (`DESC_X_ON_IDLE)
  ) u_mem (
    .clk            (clk),
    .wen            (mem_wen),
    .ren            (mem_ren),
    .mem_wr_disable (mem_wr_disable),
    .wadr           (mem_wadr),
    .radr           (mem_radr),
    .wdata          (push_desc),
    .dout           (mem_dout)
  );

  // only meaningful while pop_valid is high
  assign pop_desc = desc_t'(mem_dout);

endmodule

`default_nettype wire

// File: logic/lamb_1r1w_mem.sv
`default_nettype none

// one read, one write latch-array memory model
// the write path is staged for one cycle before it lands in the array,
// so a read address registered in the same cycle as the write still
// sees the old contents of the slot
module lamb_1r1w_mem #(
  parameter int DEPTH        = 16,
  parameter int DWIDTH       = 32,
  parameter int X_ON_NOT_REN = 1
) (
  input  wire logic                                    clk,
  input  wire logic                                    wen,
  input  wire logic                                    ren,
  input  wire logic                                    mem_wr_disable,
  input  wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] wadr,
  input  wire logic [((DEPTH > 1) ? $clog2(DEPTH) : 1)-1:0] radr,
  input  wire logic [DWIDTH-1:0]                       wdata,
  output logic      [DWIDTH-1:0]                       dout
);

  localparam int AWIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [DEPTH-1:0][DWIDTH-1:0] mem_array;

  // staged write, captured at the strobe and applied one edge later
  logic              wen_q;
  logic [AWIDTH-1:0] wadr_q;
  logic [DWIDTH-1:0] wdata_q;

  // registered read address and the idle flag for the X policy
  logic [AWIDTH-1:0] radr_q;
  logic              do_x;

  // ------------------------------
  // write side
  // ------------------------------

  // the write disable test control masks the strobe here, the caller's
  // pointers keep moving so the slot simply keeps its previous word
  always_ff @(posedge clk) begin
    wen_q   <= wen & ~mem_wr_disable;
    wadr_q  <= wadr;
    wdata_q <= wdata;
  end

  always_ff @(posedge clk) begin
    if (wen_q) begin
      mem_array[wadr_q] <= wdata_q;
    end
  end

  // ------------------------------
  // read side
  // ------------------------------

  // the address only moves on a read, do_x marks the cycle after an idle one
  always_ff @(posedge clk) begin
    if (ren) begin
      radr_q <= radr;
      do_x   <= 1'b0;
    end else begin
      do_x   <= (X_ON_NOT_REN != 0);
    end
  end

  // output is the addressed word, poisoned after idle cycles when asked
  assign dout = do_x ? {DWIDTH{1'bx}} : mem_array[radr_q];

  // an enabled address must fall inside the array, which matters once
  // the depth is not a power of two
  a_wadr_in_range : assert property (@(posedge clk) wen |-> (int'(wadr) < DEPTH))
    else $error("write address %0d beyond depth %0d", wadr, DEPTH);

  a_radr_in_range : assert property (@(posedge clk) ren |-> (int'(radr) < DEPTH))
    else $error("read address %0d beyond depth %0d", radr, DEPTH);

endmodule

`default_nettype wire

// File: logic/queue_pkg.sv
`default_nettype none

`include "desc_params.svh"

// ------------------------------
// queue fill state and errors
// ------------------------------

package queue_pkg;

  // occupancy runs from 0 up to the full depth, so one bit more than a pointer
  typedef logic [`DESC_ADDR_W:0] queue_count_t;

  // occupancy value that means the queue is full
  localparam queue_count_t QUEUE_FULL_COUNT = queue_count_t'(`DESC_QUEUE_DEPTH);

  // status bundle seen by the consumer side
  // count, full and empty are levels that follow the registered count
  // overflow and underflow are one cycle pulses after the offending strobe
  typedef struct packed {
    queue_count_t count;
    logic         full;
    logic         empty;
    logic         overflow;
    logic         underflow;
  } queue_status_t;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# build and run the descriptor queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f verilog.f --top-module desc_queue_tb -o desc_queue_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/desc_queue_sim)
sim_status=$?
printf '%s\n' "$output"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "NO ERRORS"; then
  exit 0
fi
exit 1

// File: verilog.f
+incdir+logic
+incdir+bench
logic/desc_pkg.sv
logic/queue_pkg.sv
logic/lamb_1r1w_mem.sv
logic/desc_fifo_ctrl.sv
logic/desc_queue.sv
bench/desc_queue_tb.sv
